// ==== src/uart_pkg.sv ====
/*
 * Shared definitions for the UART echo bridge.
 * Holds the fixed baud timing, the FIFO size, the byte and stream
 * types and the state encodings of the receiver and transmitter.
 * Every RTL file imports this package inside its module body.
 */
package uart_pkg;

    //////////////////////////////
    // Timing and sizes
    //////////////////////////////
    localparam int CLK_FREQ_HZ  = 1_843_200;
    localparam int BAUD_RATE    = 115_200;
    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;  // 16 clocks per bit.
    localparam int DATA_BITS    = 8;
    localparam int FIFO_DEPTH   = 8;

    localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_CNT_W  = $clog2(DATA_BITS);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    //////////////////////////////
    // Types
    //////////////////////////////
    typedef logic [DATA_BITS-1:0]  byte_t;
    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;
    typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;  // One extra bit to hold a full count.

    typedef struct packed {
        logic  valid;
        byte_t data;
    } stream_t;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_DONE
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_e;

endpackage

// ==== src/uart_rx.sv ====
/*
 * UART receiver, 8N1, LSB first.
 * Synchronizes the line, validates the start bit at half a bit period,
 * samples every data bit at its middle and checks the stop bit.
 * Good bytes leave on a registered valid/ready stream. A bad stop bit
 * pulses frame_err_o; a good byte that finds the output register busy
 * is dropped and pulses overrun_o.
 */
`timescale 1ns/1ps

module uart_rx (
    input  logic             clk_i,
    input  logic             arstn_i,
    input  logic             uart_rx_i,
    output uart_pkg::stream_t m_stream_o,
    input  logic             m_ready_i,
    output logic             frame_err_o,
    output logic             overrun_o
);

    import uart_pkg::*;

    rx_state_e state;
    logic [1:0] rx_sync;
    logic       rx_line;
    baud_cnt_t  baud_cnt;
    bit_cnt_t   bit_cnt;
    byte_t      shift_q;
    logic       stop_q;
    logic       valid_q;
    byte_t      data_q;
    logic       half_tick;
    logic       full_tick;
    logic       out_free;
    logic       load_out;
    logic       frame_err_q;
    logic       overrun_q;

    //////////////////////////////
    // Line synchronizer
    //////////////////////////////
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rx_sync <= 2'b11;  // Idle line is high.
        end else begin
            rx_sync <= {rx_sync[0], uart_rx_i};
        end
    end

    assign rx_line = rx_sync[1];

    assign half_tick = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
    assign full_tick = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

    //////////////////////////////
    // State machine and counters
    //////////////////////////////
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE:  if (!rx_line) state <= RX_START;
                RX_START: if (half_tick) state <= rx_line ? RX_IDLE : RX_DATA;
                RX_DATA: begin
                    if (full_tick && (bit_cnt == bit_cnt_t'(DATA_BITS - 1))) begin
                        state <= RX_STOP;
                    end
                end
                RX_STOP:  if (full_tick) state <= RX_DONE;
                RX_DONE:  state <= RX_IDLE;
                default:  state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if ((state == RX_IDLE) || (state == RX_DONE) || full_tick ||
                ((state == RX_START) && half_tick)) begin
                baud_cnt <= '0;  // Restart at the start-bit middle.
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            if (state == RX_IDLE) begin
                bit_cnt <= '0;
            end else if ((state == RX_DATA) && full_tick) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state == RX_DATA) && full_tick) begin
            shift_q <= {rx_line, shift_q[DATA_BITS-1:1]};  // LSB arrives first.
        end
        if ((state == RX_STOP) && full_tick) begin
            stop_q <= rx_line;
        end
    end

    //////////////////////////////
    // Output register and status
    //////////////////////////////
    assign out_free = !valid_q || m_ready_i;
    assign load_out = (state == RX_DONE) && stop_q && out_free;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
            overrun_q   <= 1'b0;
        end else begin
            if (load_out) begin
                valid_q <= 1'b1;
            end else if (m_ready_i) begin
                valid_q <= 1'b0;
            end
            frame_err_q <= (state == RX_DONE) && !stop_q;
            overrun_q   <= (state == RX_DONE) && stop_q && !out_free;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_out) begin
            data_q <= shift_q;
        end
    end

    assign m_stream_o.valid = valid_q;
    assign m_stream_o.data  = data_q;
    assign frame_err_o      = frame_err_q;
    assign overrun_o        = overrun_q;

    // An offered byte is held until the FIFO takes it.
    a_stream_hold: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (m_stream_o.valid && !m_ready_i) |=>
            (m_stream_o.valid && $stable(m_stream_o.data)));

endmodule

// ==== src/byte_fifo.sv ====
/*
 * Synchronous byte FIFO with a valid/ready stream on each side.
 * Sits between the receiver and the transmitter of the echo bridge.
 * Ready on the write side means not full; the read side shows the
 * oldest byte whenever the FIFO holds at least one.
 */
`timescale 1ns/1ps

module byte_fifo (
    input  logic              clk_i,
    input  logic              arstn_i,
    input  uart_pkg::stream_t s_stream_i,
    output logic              s_ready_o,
    output uart_pkg::stream_t m_stream_o,
    input  logic              m_ready_i
);

    import uart_pkg::*;

    byte_t     mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      wr_en;
    logic      rd_en;

    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
        return (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign s_ready_o = (count != fifo_cnt_t'(FIFO_DEPTH));
    assign wr_en     = s_stream_i.valid && s_ready_o;
    assign rd_en     = m_stream_o.valid && m_ready_i;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (rd_en) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_stream_i.data;
        end
    end

    assign m_stream_o.valid = (count != '0);
    assign m_stream_o.data  = mem[rd_ptr];

    // A write at full would push the count past the depth.
    a_no_write_full: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (count == fifo_cnt_t'(FIFO_DEPTH)) |=> (count <= fifo_cnt_t'(FIFO_DEPTH)));

    // A read at empty would wrap the count around to a large value.
    a_no_read_empty: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (count == '0) |=> (count <= fifo_cnt_t'(FIFO_DEPTH)));

endmodule

// ==== src/uart_tx.sv ====
/*
 * UART transmitter, 8N1, LSB first.
 * Takes one byte from the stream while idle and clear-to-send is low,
 * then sends start, eight data bits and stop, each CLKS_PER_BIT clocks.
 * Clear-to-send is only looked at between frames.
 */
`timescale 1ns/1ps

module uart_tx (
    input  logic              clk_i,
    input  logic              arstn_i,
    input  uart_pkg::stream_t s_stream_i,
    output logic              s_ready_o,
    input  logic              cts_n_i,
    output logic              uart_tx_o
);

    import uart_pkg::*;

    tx_state_e state;
    baud_cnt_t baud_cnt;
    bit_cnt_t  bit_cnt;
    byte_t     shift_q;
    logic      line_q;
    logic      full_tick;
    logic      last_bit;
    logic      load;
    logic      shift_en;

    assign s_ready_o = (state == TX_IDLE) && !cts_n_i;
    assign load      = s_stream_i.valid && s_ready_o;
    assign full_tick = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
    assign last_bit  = (bit_cnt == bit_cnt_t'(DATA_BITS - 1));
    assign shift_en  = full_tick && ((state == TX_START) || ((state == TX_DATA) && !last_bit));

    //////////////////////////////
    // State machine and line
    //////////////////////////////
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            line_q   <= 1'b1;
        end else begin
            if ((state == TX_IDLE) || full_tick) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                    if (load) begin
                        state  <= TX_START;
                        line_q <= 1'b0;  // Start bit.
                    end
                end
                TX_START: begin
                    if (full_tick) begin
                        state  <= TX_DATA;
                        line_q <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (full_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state  <= TX_STOP;
                            line_q <= 1'b1;  // Stop bit.
                        end else begin
                            line_q <= shift_q[0];
                        end
                    end
                end
                TX_STOP:  if (full_tick) state <= TX_IDLE;
                default:  state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            shift_q <= s_stream_i.data;
        end else if (shift_en) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign uart_tx_o = line_q;

    // Between frames the line rests at the mark level.
    a_idle_high: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (state == TX_IDLE) |-> uart_tx_o);

endmodule

// ==== src/uart_echo_top.sv ====
/*
 * UART echo bridge top level.
 * Bytes received on uart_rx_i are queued in a small FIFO and sent
 * back out on uart_tx_o. A high cts_n_i pauses the transmitter
 * between frames; receiver status comes out as single-cycle pulses.
 */
`timescale 1ns/1ps

module uart_echo_top (
    input  logic clk_i,
    input  logic arstn_i,
    input  logic uart_rx_i,
    input  logic cts_n_i,
    output logic uart_tx_o,
    output logic frame_err_o,
    output logic overrun_o
);

    import uart_pkg::*;

    stream_t rx_stream;
    logic    rx_ready;
    stream_t tx_stream;
    logic    tx_ready;

    uart_rx u_rx (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .uart_rx_i   (uart_rx_i),
        .m_stream_o  (rx_stream),
        .m_ready_i   (rx_ready),
        .frame_err_o (frame_err_o),
        .overrun_o   (overrun_o)
    );

    byte_fifo u_fifo (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .s_stream_i (rx_stream),
        .s_ready_o  (rx_ready),
        .m_stream_o (tx_stream),
        .m_ready_i  (tx_ready)
    );

    uart_tx u_tx (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .s_stream_i (tx_stream),
        .s_ready_o  (tx_ready),
        .cts_n_i    (cts_n_i),
        .uart_tx_o  (uart_tx_o)
    );

endmodule

// ==== tests/uart_echo_tb.sv ====
/*
 * Testbench for the UART echo bridge.
 * Reads commands from tests/uart_echo_patterns.txt, drives serial frames
 * into uart_rx_i, decodes the echo on uart_tx_o and checks the bytes and
 * status pulses against a small model of the bridge.
 * Run from the project root so that the pattern file is found.
 */
`timescale 1ns/1ps

module uart_echo_tb;

    localparam int BIT_CLKS   = uart_pkg::CLKS_PER_BIT;
    localparam int CAPACITY   = uart_pkg::FIFO_DEPTH + 1;  // FIFO plus receiver register.
    localparam int CLK_PERIOD = 40;

    logic clk_i;
    logic arstn_i;
    logic uart_rx_i;
    logic cts_n_i;
    logic uart_tx_o;
    logic frame_err_o;
    logic overrun_o;

    logic [7:0] got_q[$];
    logic [7:0] exp_q[$];
    int         fe_seen        = 0;
    int         ovr_seen       = 0;
    int         held_starts    = 0;
    int         bad_echo_stops = 0;
    int         exp_fe         = 0;
    int         exp_ovr        = 0;
    int         pass_count     = 0;
    int         fail_count     = 0;
    longint     budget_ns      = 0;

    uart_echo_top uut (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .uart_rx_i   (uart_rx_i),
        .cts_n_i     (cts_n_i),
        .uart_tx_o   (uart_tx_o),
        .frame_err_o (frame_err_o),
        .overrun_o   (overrun_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    //////////////////////////////
    // Monitors
    //////////////////////////////
    always @(negedge clk_i) begin
        if (frame_err_o === 1'b1) fe_seen = fe_seen + 1;
        if (overrun_o === 1'b1) ovr_seen = ovr_seen + 1;
    end

    // Samples the echoed line in the middle of every bit.
    initial begin : line_decoder
        logic [7:0] b;
        @(posedge arstn_i);
        forever begin
            @(negedge clk_i);
            if (uart_tx_o === 1'b0) begin
                if (cts_n_i === 1'b1) held_starts = held_starts + 1;
                repeat (BIT_CLKS / 2) @(negedge clk_i);  // Middle of the start bit.
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge clk_i);
                    b[i] = uart_tx_o;
                end
                repeat (BIT_CLKS) @(negedge clk_i);
                if (uart_tx_o !== 1'b1) bad_echo_stops = bad_echo_stops + 1;
                got_q.push_back(b);
            end
        end
    end

    initial begin : watchdog
        wait (budget_ns > 0);
        #(budget_ns);
        $display("Timeout: the run did not finish within %0d ns", budget_ns);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////
    // Line tasks
    //////////////////////////////
    task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
        uart_rx_i = 1'b0;
        repeat (BIT_CLKS) @(negedge clk_i);
        for (int i = 0; i < 8; i++) begin
            uart_rx_i = data[i];  // LSB first.
            repeat (BIT_CLKS) @(negedge clk_i);
        end
        uart_rx_i = stop_bit;
        repeat (BIT_CLKS) @(negedge clk_i);
        uart_rx_i = 1'b1;
    endtask

    task automatic drive_glitch(input int clks);
        uart_rx_i = 1'b0;
        repeat (clks) @(negedge clk_i);
        uart_rx_i = 1'b1;
    endtask

    // No frame holds the line high for more than nine bits.
    task automatic wait_line_idle();
        int quiet;
        quiet = 0;
        while (quiet < 12 * BIT_CLKS) begin
            @(negedge clk_i);
            if (uart_tx_o === 1'b1) quiet = quiet + 1;
            else quiet = 0;
        end
    endtask

    task automatic close_test(input string name);
        logic [7:0] exp_b;
        logic [7:0] got_b;
        logic       ok;
        ok = 1'b1;
        wait_line_idle();
        while ((exp_q.size() > 0) && (got_q.size() > 0)) begin
            exp_b = exp_q.pop_front();
            got_b = got_q.pop_front();
            if (got_b !== exp_b) begin
                $display("FAILED %s: echoed byte expected 0x%02h, actual 0x%02h",
                         name, exp_b, got_b);
                ok = 1'b0;
            end
        end
        if (exp_q.size() > 0) begin
            $display("%s: %0d expected bytes never came back", name, exp_q.size());
            ok = 1'b0;
        end
        if (got_q.size() > 0) begin
            $display("%s: %0d bytes came back that were not expected", name, got_q.size());
            ok = 1'b0;
        end
        if (fe_seen != exp_fe) begin
            $display("FAILED %s: frame errors expected %0d, actual %0d", name, exp_fe, fe_seen);
            ok = 1'b0;
        end
        if (ovr_seen != exp_ovr) begin
            $display("FAILED %s: overruns expected %0d, actual %0d", name, exp_ovr, ovr_seen);
            ok = 1'b0;
        end
        if (held_starts != 0) begin
            $display("%s: the transmitter started while clear-to-send was held", name);
            ok = 1'b0;
        end
        if (bad_echo_stops != 0) begin
            $display("%s: an echoed frame had a low stop bit", name);
            ok = 1'b0;
        end
        exp_q.delete();
        got_q.delete();
        {fe_seen, ovr_seen, held_starts, bad_echo_stops, exp_fe, exp_ovr} = '0;
        if (ok) pass_count = pass_count + 1;
        else fail_count = fail_count + 1;
        $display("%s: %s", name, ok ? "passed" : "failed");
    endtask

    //////////////////////////////
    // Pattern reader and sequencer
    //////////////////////////////
    initial begin : run_patterns
        int              fd;
        int              code;
        int              val;
        int              frames;
        int              wait_bits;
        int              closes;
        int              held_count;
        logic            held;
        logic [7:0]      byte_v;
        logic [8*200-1:0] skip_buf;
        string           cmd;
        string           name;
        string           cmd_q[$];
        int              arg_q[$];
        string           name_q[$];

        arstn_i    = 1'b0;
        uart_rx_i  = 1'b1;
        cts_n_i    = 1'b0;
        frames     = 0;
        wait_bits  = 0;
        closes     = 0;
        held_count = 0;
        held       = 1'b0;

        fd = $fopen("tests/uart_echo_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/uart_echo_patterns.txt");
            fail_count = fail_count + 1;
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                val  = 0;
                name = "";
                code = 1;
                if (cmd == "#") begin
                    void'($fgets(skip_buf, fd));
                end else if ((cmd == "S") || (cmd == "B")) begin
                    code   = $fscanf(fd, "%h", val);
                    frames = frames + 1;
                end else if ((cmd == "W") || (cmd == "G")) begin
                    code = $fscanf(fd, "%d", val);
                    if (cmd == "W") wait_bits = wait_bits + val;
                end else if (cmd == "C") begin
                    code   = $fscanf(fd, "%s", name);
                    closes = closes + 1;
                end else if ((cmd != "H") && (cmd != "R")) begin
                    $display("Unknown command %s in the pattern file", cmd);
                    fail_count = fail_count + 1;
                end
                if (code != 1) begin
                    $display("Missing argument after %s in the pattern file", cmd);
                    fail_count = fail_count + 1;
                end
                if (cmd != "#") begin
                    cmd_q.push_back(cmd);
                    arg_q.push_back(val);
                    name_q.push_back(name);
                end
            end
            $fclose(fd);
        end

        // Each frame crosses the line twice, once in and once echoed.
        budget_ns = longint'(24 * frames + wait_bits + 12 * closes + 100) *
                    BIT_CLKS * CLK_PERIOD;

        repeat (3) @(negedge clk_i);
        arstn_i = 1'b1;
        repeat (BIT_CLKS) @(negedge clk_i);

        foreach (cmd_q[k]) begin
            byte_v = arg_q[k][7:0];
            if (cmd_q[k] == "S") begin
                drive_frame(byte_v, 1'b1);
                if (held && (held_count >= CAPACITY)) begin
                    exp_ovr = exp_ovr + 1;
                end else begin
                    exp_q.push_back(byte_v);
                    if (held) held_count = held_count + 1;
                end
            end else if (cmd_q[k] == "B") begin
                drive_frame(byte_v, 1'b0);
                repeat (BIT_CLKS) @(negedge clk_i);  // Idle bit after a bad stop.
                exp_fe = exp_fe + 1;
            end else if (cmd_q[k] == "G") begin
                drive_glitch(arg_q[k]);
            end else if (cmd_q[k] == "W") begin
                repeat (arg_q[k] * BIT_CLKS) @(negedge clk_i);
            end else if (cmd_q[k] == "H") begin
                cts_n_i = 1'b1;
                held    = 1'b1;
            end else if (cmd_q[k] == "R") begin
                cts_n_i    = 1'b0;
                held       = 1'b0;
                held_count = 0;
            end else if (cmd_q[k] == "C") begin
                close_test(name_q[k]);
            end
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/uart_echo_patterns.txt ====
# Columns: command, argument. S/B hex byte = good/bad-stop frame, H/R = hold/release CTS,
# W n = wait n bit periods, G n = low glitch of n clocks, C name = close a named test.
S 5A
C single_echo
S 00
S FF
S 55
S 01
S 80
S 3C
S C3
S AA
S 7E
S 12
C back_to_back
B A5
S 3C
C framing_error
H
S 11
S 22
S 33
S 44
W 20
R
C pause_resume
H
S 01
S 02
S 03
S 04
S 05
S 06
S 07
S 08
S 09
S 0A
S 0B
W 10
R
C overrun
G 5
W 4
C glitch_reject

// ==== flist.f ====
src/uart_pkg.sv
src/uart_rx.sv
src/byte_fifo.sv
src/uart_tx.sv
src/uart_echo_top.sv
tests/uart_echo_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the UART echo bridge.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= uart_echo_tb
RTL_TOP   ?= uart_echo_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS := $(filter src/%,$(shell cat $(FLIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
